// File: sdramCtrlPkg.sv
`default_nettype none

package sdramCtrlPkg;

    //*********************************************************************
    // Timing in clocks
    //*********************************************************************
    localparam int unsigned InitWaitCycles  = 20;   // Power-up wait, shortened for simulation
    localparam int unsigned TRp             = 2;    // Precharge to next command
    localparam int unsigned TRcd            = 2;    // Activate to read or write
    localparam int unsigned TRfc            = 7;    // Refresh to next command
    localparam int unsigned TWr             = 2;    // Last write beat to precharge
    localparam int unsigned CasLatency      = 2;
    localparam int unsigned BurstLength     = 8;
    localparam int unsigned RefreshInterval = 300;  // Far below the real 7.8 us

    //*********************************************************************
    // Request address fields
    //*********************************************************************
    localparam int unsigned BankHi = 25;
    localparam int unsigned BankLo = 24;
    localparam int unsigned RowHi  = 23;
    localparam int unsigned RowLo  = 11;
    localparam int unsigned ColHi  = 10;
    localparam int unsigned ColLo  = 1;     // Bit 0 is the byte within a 16-bit word

    // Write burst follows read burst, CAS 2, sequential, burst length 8
    localparam logic [12:0] ModeRegValue = 13'b000_0_00_010_0_011;

    // Encoded as {CsN, RasN, CasN, WeN} so it drives the pins directly
    typedef enum logic [3:0] {
        CmdNop       = 4'b0111,
        CmdActive    = 4'b0011,
        CmdRead      = 4'b0101,
        CmdWrite     = 4'b0100,
        CmdPrecharge = 4'b0010,
        CmdRefresh   = 4'b0001,
        CmdLoadMode  = 4'b0000
    } sdramCmd;

    typedef enum logic [3:0] {
        StInitWait,
        StInitPre,
        StInitRef1,
        StInitRef2,
        StInitMode,
        StIdle,
        StRefresh,
        StActivate,
        StWriteBurst,
        StReadBurst,
        StReadDrain,
        StRecover
    } ctrlState;

    typedef enum logic [2:0] {
        TstIdle,
        TstWrite,
        TstWaitW,
        TstRead,
        TstWaitR,
        TstDone
    } testerState;

endpackage

`default_nettype wire

// File: sdramTimer.sv
`timescale 1ns/1ps
`default_nettype none

module sdramTimer (
    input  logic        Clock,
    input  logic        Reset,
    input  logic        LoadCount,
    input  logic [15:0] LoadValue,
    input  logic        RefreshAck,
    output logic        WaitDone,
    output logic        RefreshDue
);
    import sdramCtrlPkg::*;

    logic [15:0] WaitCount;     // Spacing between DRAM commands
    logic [15:0] RefreshCount;  // Free-running refresh interval
    logic        RefreshRun;    // Set once init has issued its refreshes

    always_ff @(posedge Clock) begin
        if (Reset) begin
            WaitCount <= 16'd0;
        end else if (LoadCount) begin
            WaitCount <= LoadValue;
        end else if (WaitCount != 16'd0) begin
            WaitCount <= WaitCount - 16'd1;  // Sticks at zero until the next load
        end
    end

    assign WaitDone = (WaitCount == 16'd0);

    always_ff @(posedge Clock) begin
        if (Reset) begin
            RefreshRun   <= 1'b0;
            RefreshCount <= 16'd0;
            RefreshDue   <= 1'b0;
        end else begin
            if (RefreshAck)
                RefreshRun <= 1'b1;
            if (RefreshRun) begin
                if (RefreshCount == 16'(RefreshInterval - 1))
                    RefreshCount <= 16'd0;
                else
                    RefreshCount <= RefreshCount + 16'd1;
            end
            if (RefreshAck)
                RefreshDue <= 1'b0;  // Acknowledge wins over a new interval in the same cycle
            else if (RefreshRun && RefreshCount == 16'(RefreshInterval - 1))
                RefreshDue <= 1'b1;  // Held until the FSM gets to it
        end
    end

endmodule

`default_nettype wire

// File: sdramCtrlFsm.sv
`timescale 1ns/1ps
`default_nettype none

module sdramCtrlFsm (
    input  logic                  Clock,
    input  logic                  Reset,
    input  logic                  WriteReq,
    input  logic                  ReadReq,
    input  logic                  WaitDone,
    input  logic                  RefreshDue,
    output logic                  Busy,
    output logic                  WriteDataTake,
    output logic                  LoadCount,
    output logic                  RefreshAck,
    output logic                  RowSel,
    output logic                  ColSel,
    output logic                  ModeSel,
    output logic                  WriteEnable,
    output logic                  ReadExpect,
    output logic                  CkeOn,
    output logic [15:0]           LoadValue,
    output sdramCtrlPkg::sdramCmd Cmd
);
    import sdramCtrlPkg::*;

    ctrlState   State, NextState;
    logic       FirstCycle;  // High on the first cycle spent in a state
    logic       IsWrite;     // Kind of the accepted request
    logic [2:0] Beat;        // Data beat within the burst

    always_ff @(posedge Clock) begin
        if (Reset) begin
            State      <= StInitWait;
            FirstCycle <= 1'b1;
            IsWrite    <= 1'b0;
            Beat       <= 3'd0;
        end else begin
            State      <= NextState;
            FirstCycle <= (NextState != State);
            if (State == StIdle && !RefreshDue && (WriteReq || ReadReq))
                IsWrite <= WriteReq;
            Beat <= (State == StWriteBurst || State == StReadDrain) ? Beat + 3'd1 : 3'd0;
        end
    end

    // A refresh waiting in IDLE counts as busy so no strobe is lost to it
    assign Busy  = (State != StIdle) || RefreshDue;
    assign CkeOn = (State != StInitWait);

    //*********************************************************************
    // Command sequencing
    //*********************************************************************
    // A state issues its command and loads the timer on its first cycle,
    // then leaves two cycles after the loaded value once WaitDone is seen
    always_comb begin
        NextState     = State;
        Cmd           = CmdNop;
        LoadCount     = 1'b0;
        LoadValue     = 16'd0;
        RefreshAck    = 1'b0;
        RowSel        = 1'b0;
        ColSel        = 1'b0;
        ModeSel       = 1'b0;
        WriteDataTake = 1'b0;
        WriteEnable   = 1'b0;
        ReadExpect    = 1'b0;
        case (State)
            StInitWait: begin
                if (FirstCycle) begin
                    LoadCount = 1'b1;
                    LoadValue = 16'(InitWaitCycles - 2);
                end else if (WaitDone)
                    NextState = StInitPre;
            end
            StInitPre: begin
                if (FirstCycle) begin
                    Cmd       = CmdPrecharge;  // A10 high from the data path closes all banks
                    LoadCount = 1'b1;
                    LoadValue = 16'(TRp - 2);
                end else if (WaitDone)
                    NextState = StInitRef1;
            end
            StInitRef1, StInitRef2: begin
                if (FirstCycle) begin
                    Cmd        = CmdRefresh;
                    LoadCount  = 1'b1;
                    LoadValue  = 16'(TRfc - 2);
                    RefreshAck = (State == StInitRef2);  // Starts the refresh interval
                end else if (WaitDone)
                    NextState = (State == StInitRef1) ? StInitRef2 : StInitMode;
            end
            StInitMode: begin
                if (FirstCycle) begin
                    Cmd       = CmdLoadMode;
                    ModeSel   = 1'b1;
                    LoadCount = 1'b1;
                    LoadValue = 16'd0;  // Two clocks of mode-register setup
                end else if (WaitDone)
                    NextState = StIdle;
            end
            StIdle: begin
                if (RefreshDue)
                    NextState = StRefresh;
                else if (WriteReq || ReadReq)
                    NextState = StActivate;
            end
            StRefresh: begin
                if (FirstCycle) begin
                    Cmd        = CmdRefresh;
                    RefreshAck = 1'b1;
                    LoadCount  = 1'b1;
                    LoadValue  = 16'(TRfc - 2);
                end else if (WaitDone)
                    NextState = StIdle;
            end
            StActivate: begin
                if (FirstCycle) begin
                    Cmd       = CmdActive;
                    RowSel    = 1'b1;
                    LoadCount = 1'b1;
                    LoadValue = 16'(TRcd - 2);
                end else if (WaitDone)
                    NextState = IsWrite ? StWriteBurst : StReadBurst;
            end
            StWriteBurst: begin
                WriteDataTake = 1'b1;  // Beat is registered with the command pins
                WriteEnable   = 1'b1;
                if (Beat == 3'd0) begin
                    Cmd    = CmdWrite;
                    ColSel = 1'b1;
                end
                if (Beat == 3'(BurstLength - 1)) begin
                    LoadCount = 1'b1;
                    LoadValue = 16'(TWr + TRp - 1);  // Write recovery plus auto-precharge
                    NextState = StRecover;
                end
            end
            StReadBurst: begin
                Cmd       = CmdRead;
                ColSel    = 1'b1;
                NextState = StReadDrain;
            end
            StReadDrain: begin
                ReadExpect = 1'b1;  // Lags READ by one cycle to line up with CAS latency
                if (Beat == 3'(BurstLength - 1)) begin
                    LoadCount = 1'b1;
                    LoadValue = 16'(CasLatency);  // Last beat still in the capture path
                    NextState = StRecover;
                end
            end
            StRecover: begin
                if (WaitDone)
                    NextState = StIdle;
            end
            default: NextState = StIdle;
        endcase
    end

endmodule

`default_nettype wire

// File: sdramDataPath.sv
`timescale 1ns/1ps
`default_nettype none

module sdramDataPath (
    input  logic                  Clock,
    input  logic                  Reset,
    input  logic [31:0]           Address,
    input  logic [15:0]           WriteData,
    input  sdramCtrlPkg::sdramCmd Cmd,
    input  logic                  RowSel,
    input  logic                  ColSel,
    input  logic                  ModeSel,
    input  logic                  WriteEnable,
    input  logic                  ReadExpect,
    input  logic                  CkeOn,
    input  logic [15:0]           DramDqIn,
    output logic                  ReadValid,
    output logic [15:0]           ReadData,
    output logic [12:0]           DramAddr,
    output logic [1:0]            DramBa,
    output logic                  DramCsN,
    output logic                  DramRasN,
    output logic                  DramCasN,
    output logic                  DramWeN,
    output logic                  DramCke,
    output logic                  DramDqml,
    output logic                  DramDqmh,
    output logic                  DramDqOe,
    output logic [15:0]           DramDqOut
);
    import sdramCtrlPkg::*;

    sdramCmd               CmdPins;     // Command as it sits on the pins
    logic [1:0]            ReqBank;     // Bank of the open row
    logic [ColHi-ColLo:0]  ReqCol;      // Column held from ACTIVE until READ or WRITE
    logic [CasLatency-1:0] ExpectPipe;  // Read beats in flight inside the DRAM

    always_ff @(posedge Clock) begin
        if (RowSel) begin
            ReqBank <= Address[BankHi:BankLo];
            ReqCol  <= Address[ColHi:ColLo];
        end
        if (RowSel) begin
            DramAddr <= Address[RowHi:RowLo];
            DramBa   <= Address[BankHi:BankLo];
        end else if (ColSel) begin
            DramAddr <= {2'b00, 1'b1, ReqCol};  // A10 requests auto-precharge
            DramBa   <= ReqBank;
        end else if (ModeSel) begin
            DramAddr <= ModeRegValue;
            DramBa   <= 2'b00;
        end else begin
            DramAddr <= 13'h0400;  // A10 high so PRECHARGE means all banks
        end
        DramDqOut <= WriteData;
        if (ExpectPipe[CasLatency-1])
            ReadData <= DramDqIn;
    end

    always_ff @(posedge Clock) begin
        if (Reset) begin
            CmdPins    <= CmdNop;
            DramCke    <= 1'b0;
            DramDqOe   <= 1'b0;
            ExpectPipe <= '0;
            ReadValid  <= 1'b0;
        end else begin
            CmdPins    <= Cmd;
            DramCke    <= CkeOn;
            DramDqOe   <= WriteEnable;
            ExpectPipe <= {ExpectPipe[CasLatency-2:0], ReadExpect};
            ReadValid  <= ExpectPipe[CasLatency-1];  // Valid with the captured word
        end
    end

    assign {DramCsN, DramRasN, DramCasN, DramWeN} = CmdPins;
    assign DramDqml = 1'b0;  // No byte masking
    assign DramDqmh = 1'b0;

endmodule

`default_nettype wire

// File: sdramBurstTester.sv
`timescale 1ns/1ps
`default_nettype none

module sdramBurstTester (
    input  logic        Clock,
    input  logic        Reset,
    input  logic        Busy,
    input  logic        WriteDataTake,
    input  logic        ReadValid,
    input  logic [15:0] ReadData,
    output logic [31:0] Address,
    output logic        WriteReq,
    output logic        ReadReq,
    output logic        Done,
    output logic [15:0] WriteData,
    output logic [7:0]  MismatchCount
);
    import sdramCtrlPkg::*;

    testerState  State, NextState;
    logic [1:0]  BurstIdx;  // Which of the four bursts is in progress
    logic [2:0]  Beat;      // Word within the burst
    logic [15:0] Pattern;   // Word expected at BurstIdx and Beat
    logic        BeatStep;  // A word moves in this cycle
    logic        BurstEnd;

    assign Pattern   = {6'd0, BurstIdx, 5'd0, Beat};
    assign WriteData = Pattern;                      // Picked in the same cycle as WriteDataTake
    assign Address   = {26'd0, BurstIdx, 4'd0};      // Byte address of word 8 * BurstIdx
    assign BeatStep  = (State == TstWaitW && WriteDataTake) || (State == TstWaitR && ReadValid);
    assign BurstEnd  = BeatStep && (Beat == 3'd7);
    assign Done      = (State == TstDone);

    always_comb begin
        NextState = State;
        WriteReq  = 1'b0;
        ReadReq   = 1'b0;
        case (State)
            TstIdle:  if (!Busy) NextState = TstWrite;  // Init is over
            TstWrite: begin
                WriteReq = !Busy;
                if (!Busy)
                    NextState = TstWaitW;
            end
            TstWaitW: if (BurstEnd) NextState = (BurstIdx == 2'd3) ? TstRead : TstWrite;
            TstRead: begin
                ReadReq = !Busy;
                if (!Busy)
                    NextState = TstWaitR;
            end
            TstWaitR: if (BurstEnd) NextState = (BurstIdx == 2'd3) ? TstDone : TstRead;
            TstDone:  NextState = TstDone;
            default:  NextState = TstDone;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (Reset) begin
            State         <= TstIdle;
            BurstIdx      <= 2'd0;
            Beat          <= 3'd0;
            MismatchCount <= 8'd0;
        end else begin
            State <= NextState;
            if (BurstEnd)
                BurstIdx <= BurstIdx + 2'd1;  // Wraps to zero for the read pass
            if (BeatStep)
                Beat <= Beat + 3'd1;
            if (State == TstWaitR && ReadValid && ReadData != Pattern && MismatchCount != 8'hFF)
                MismatchCount <= MismatchCount + 8'd1;
        end
    end

endmodule

`default_nettype wire

// File: sdramBurstsTop.sv
`timescale 1ns/1ps
`default_nettype none

module sdramBurstsTop (
    input  logic        Clock,
    input  logic        Reset,
    output logic        Done,
    output logic [7:0]  MismatchCount,
    input  logic [15:0] DramDqIn,
    output logic [12:0] DramAddr,
    output logic [1:0]  DramBa,
    output logic        DramCsN,
    output logic        DramRasN,
    output logic        DramCasN,
    output logic        DramWeN,
    output logic        DramCke,
    output logic        DramDqml,
    output logic        DramDqmh,
    output logic        DramDqOe,
    output logic [15:0] DramDqOut
);
    import sdramCtrlPkg::*;

    //*********************************************************************
    // Tester to controller
    //*********************************************************************
    logic [31:0] Address;
    logic        WriteReq, ReadReq;
    logic [15:0] WriteData, ReadData;
    logic        Busy, WriteDataTake, ReadValid;

    // Inside the controller
    logic        LoadCount, WaitDone, RefreshDue, RefreshAck;
    logic [15:0] LoadValue;
    logic        RowSel, ColSel, ModeSel, WriteEnable, ReadExpect, CkeOn;
    sdramCmd     Cmd;

    sdramBurstTester uTester (
        .Clock(Clock), .Reset(Reset), .Busy(Busy), .WriteDataTake(WriteDataTake),
        .ReadValid(ReadValid), .ReadData(ReadData), .Address(Address),
        .WriteReq(WriteReq), .ReadReq(ReadReq), .Done(Done), .WriteData(WriteData),
        .MismatchCount(MismatchCount)
    );

    sdramCtrlFsm uFsm (
        .Clock(Clock), .Reset(Reset), .WriteReq(WriteReq), .ReadReq(ReadReq),
        .WaitDone(WaitDone), .RefreshDue(RefreshDue), .Busy(Busy),
        .WriteDataTake(WriteDataTake), .LoadCount(LoadCount), .RefreshAck(RefreshAck),
        .RowSel(RowSel), .ColSel(ColSel), .ModeSel(ModeSel), .WriteEnable(WriteEnable),
        .ReadExpect(ReadExpect), .CkeOn(CkeOn), .LoadValue(LoadValue), .Cmd(Cmd)
    );

    sdramTimer uTimer (
        .Clock(Clock), .Reset(Reset), .LoadCount(LoadCount), .LoadValue(LoadValue),
        .RefreshAck(RefreshAck), .WaitDone(WaitDone), .RefreshDue(RefreshDue)
    );

    sdramDataPath uDataPath (
        .Clock(Clock), .Reset(Reset), .Address(Address), .WriteData(WriteData),
        .Cmd(Cmd), .RowSel(RowSel), .ColSel(ColSel), .ModeSel(ModeSel),
        .WriteEnable(WriteEnable), .ReadExpect(ReadExpect), .CkeOn(CkeOn),
        .DramDqIn(DramDqIn), .ReadValid(ReadValid), .ReadData(ReadData),
        .DramAddr(DramAddr), .DramBa(DramBa), .DramCsN(DramCsN), .DramRasN(DramRasN),
        .DramCasN(DramCasN), .DramWeN(DramWeN), .DramCke(DramCke), .DramDqml(DramDqml),
        .DramDqmh(DramDqmh), .DramDqOe(DramDqOe), .DramDqOut(DramDqOut)
    );

endmodule

`default_nettype wire

// File: sdramModel.sv
`timescale 1ns/1ps
`default_nettype none

module sdramModel (
    input  logic        Clock,
    input  logic        DramCke,
    input  logic        DramCsN,
    input  logic        DramRasN,
    input  logic        DramCasN,
    input  logic        DramWeN,
    input  logic [12:0] DramAddr,
    input  logic [1:0]  DramBa,
    input  logic        DramDqOe,
    input  logic [15:0] DramDqOut,
    input  logic        FaultArm,
    input  logic [9:0]  FaultCol,
    output logic [15:0] DramDqIn
);
    import sdramCtrlPkg::*;

    logic [15:0] Mem [logic [24:0]];  // Sparse store keyed by {bank, row, column}
    logic [12:0] OpenRow [4];         // Row opened by ACTIVE in each bank
    sdramCmd     PinCmd;
    logic [1:0]  BurstBank = 2'd0;
    logic [9:0]  BurstCol  = 10'd0;   // Start column of the running burst
    logic [2:0]  BurstBeat = 3'd0;
    logic [3:0]  WriteLeft = 4'd0;    // Write beats still due after the WRITE cycle
    logic [3:0]  ReadLeft  = 4'd0;    // Read beats still to put on the bus
    logic [1:0]  ReadWait  = 2'd0;    // Idle cycles before the first read beat
    logic [15:0] DqReg     = 16'd0;

    assign PinCmd   = sdramCmd'({DramCsN, DramRasN, DramCasN, DramWeN});
    assign DramDqIn = DqReg;

    // Sequential order wraps inside the aligned block of eight columns
    function automatic logic [9:0] beatCol(input logic [9:0] col, input logic [2:0] beat);
        beatCol = {col[9:3], col[2:0] + beat};
    endfunction

    function automatic logic [24:0] wordKey(input logic [1:0] bank, input logic [9:0] col);
        wordKey = {bank, OpenRow[bank], col};
    endfunction

    // An armed fault stores the chosen word with every bit flipped
    function automatic logic [15:0] storedWord(input logic [9:0] col, input logic [15:0] data);
        storedWord = (FaultArm && col == FaultCol) ? ~data : data;
    endfunction

    //*********************************************************************
    // Command decode and burst engine
    //*********************************************************************
    always @(posedge Clock) begin
        if (DramCke && PinCmd == CmdActive)
            OpenRow[DramBa] <= DramAddr;
        if (DramCke && PinCmd == CmdWrite) begin
            if (DramDqOe)
                Mem[wordKey(DramBa, DramAddr[9:0])] = storedWord(DramAddr[9:0], DramDqOut);
            BurstBank <= DramBa;
            BurstCol  <= DramAddr[9:0];
            BurstBeat <= 3'd1;                        // Beat 0 is taken with the command
            WriteLeft <= 4'(BurstLength - 1);
        end else if (WriteLeft != 4'd0) begin
            if (DramDqOe)
                Mem[wordKey(BurstBank, beatCol(BurstCol, BurstBeat))] =
                    storedWord(beatCol(BurstCol, BurstBeat), DramDqOut);
            BurstBeat <= BurstBeat + 3'd1;
            WriteLeft <= WriteLeft - 4'd1;
        end
        if (DramCke && PinCmd == CmdRead) begin
            BurstBank <= DramBa;
            BurstCol  <= DramAddr[9:0];
            BurstBeat <= 3'd0;
            ReadLeft  <= 4'(BurstLength);
            ReadWait  <= 2'(CasLatency - 2);          // Data is valid at the CAS latency edge
        end else if (ReadLeft != 4'd0) begin
            if (ReadWait != 2'd0) begin
                ReadWait <= ReadWait - 2'd1;
            end else begin
                DqReg     <= Mem[wordKey(BurstBank, beatCol(BurstCol, BurstBeat))];
                BurstBeat <= BurstBeat + 3'd1;
                ReadLeft  <= ReadLeft - 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tbSdramBursts.sv
`timescale 1ns/1ps
`default_nettype none

module tbSdramBursts;
    import sdramCtrlPkg::*;

    localparam int unsigned ClockPeriod = 40;
    localparam int unsigned ResetCycles = 4;
    localparam int unsigned CycleLimit  = 3000;  // Two runs of about 400 cycles plus refreshes

    logic        Clock;
    logic        Reset;
    logic        Done;
    logic [7:0]  MismatchCount;
    logic [15:0] DramDqIn;
    logic [12:0] DramAddr;
    logic [1:0]  DramBa;
    logic        DramCsN;
    logic        DramRasN;
    logic        DramCasN;
    logic        DramWeN;
    logic        DramCke;
    logic        DramDqml;
    logic        DramDqmh;
    logic        DramDqOe;
    logic [15:0] DramDqOut;
    logic        FaultArm;
    logic [9:0]  FaultCol;                       // Column whose stored word gets corrupted

    int unsigned ErrorCount = 0;
    int unsigned RunsDone   = 0;
    int unsigned CycleCount = 0;

    // Command monitor state
    logic [3:0]  PinBits;
    sdramCmd     PinCmd;
    sdramCmd     InitExpect;                     // Next command of the init sequence
    logic [15:0] InitCycles;                     // Clocks since reset was released
    logic [2:0]  CmdCount;                       // Non-NOP commands seen, stops at four
    logic [15:0] SinceActive;
    logic [15:0] SinceRefresh;
    logic        RefreshSeen;                    // A REFRESH came after init
    logic [1:0]  WriteCount;                     // Index of the next write burst
    logic [1:0]  WrBurst;
    logic [2:0]  WrBeat;                         // Beat after WRITE, zero when no burst runs
    logic        WriteBeatNow;
    logic [15:0] ExpectDq;

    sdramBurstsTop u_dut (
        .Clock(Clock), .Reset(Reset), .Done(Done), .MismatchCount(MismatchCount),
        .DramDqIn(DramDqIn), .DramAddr(DramAddr), .DramBa(DramBa), .DramCsN(DramCsN),
        .DramRasN(DramRasN), .DramCasN(DramCasN), .DramWeN(DramWeN), .DramCke(DramCke),
        .DramDqml(DramDqml), .DramDqmh(DramDqmh), .DramDqOe(DramDqOe),
        .DramDqOut(DramDqOut)
    );

    sdramModel uModel (
        .Clock(Clock), .DramCke(DramCke), .DramCsN(DramCsN), .DramRasN(DramRasN),
        .DramCasN(DramCasN), .DramWeN(DramWeN), .DramAddr(DramAddr), .DramBa(DramBa),
        .DramDqOe(DramDqOe), .DramDqOut(DramDqOut), .FaultArm(FaultArm),
        .FaultCol(FaultCol), .DramDqIn(DramDqIn)
    );

    // Burst index in the upper byte, beat number in the lower byte
    function automatic logic [15:0] patternWord(input logic [1:0] burst, input logic [2:0] beat);
        patternWord = {8'(burst), 8'(beat)};
    endfunction

    function automatic sdramCmd initStepCmd(input logic [2:0] step);
        case (step)
            3'd0:       initStepCmd = CmdPrecharge;
            3'd1, 3'd2: initStepCmd = CmdRefresh;
            3'd3:       initStepCmd = CmdLoadMode;
            default:    initStepCmd = CmdNop;
        endcase
    endfunction

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        ErrorCount++;
        $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
    endtask

    task automatic reportRule(input string msg);
        ErrorCount++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    //*********************************************************************
    // Command monitor
    //*********************************************************************
    assign PinBits      = {DramCsN, DramRasN, DramCasN, DramWeN};
    assign PinCmd       = sdramCmd'(PinBits);
    assign InitExpect   = initStepCmd(CmdCount);
    assign WriteBeatNow = (PinCmd == CmdWrite) || (WrBeat != 3'd0);
    assign ExpectDq     = (PinCmd == CmdWrite) ? patternWord(WriteCount, 3'd0)
                                               : patternWord(WrBurst, WrBeat);

    always_ff @(posedge Clock) begin
        if (Reset) begin
            InitCycles   <= 16'd0;
            CmdCount     <= 3'd0;
            SinceActive  <= 16'hFFFF;
            SinceRefresh <= 16'd0;
            RefreshSeen  <= 1'b0;
            WriteCount   <= 2'd0;
            WrBurst      <= 2'd0;
            WrBeat       <= 3'd0;
        end else begin
            if (InitCycles != 16'hFFFF)
                InitCycles <= InitCycles + 16'd1;
            if (PinCmd != CmdNop && CmdCount != 3'd4)
                CmdCount <= CmdCount + 3'd1;
            if (PinCmd == CmdActive)
                SinceActive <= 16'd1;
            else if (SinceActive != 16'hFFFF)
                SinceActive <= SinceActive + 16'd1;
            if (PinCmd == CmdRefresh)
                SinceRefresh <= 16'd1;
            else if (SinceRefresh != 16'hFFFF)
                SinceRefresh <= SinceRefresh + 16'd1;
            if (PinCmd == CmdRefresh && CmdCount == 3'd4)
                RefreshSeen <= 1'b1;
            if (PinCmd == CmdWrite) begin
                WriteCount <= WriteCount + 2'd1;
                WrBurst    <= WriteCount;
                WrBeat     <= 3'd1;
            end else if (WrBeat != 3'd0) begin
                WrBeat <= WrBeat + 3'd1;        // Back to idle after beat 7
            end
        end
    end

    //*********************************************************************
    // Protocol checks
    //*********************************************************************
    assert property (@(posedge Clock) disable iff (Reset)
        InitCycles < 16'(InitWaitCycles) |-> !DramCke)
        else reportRule("DramCke went high before the init wait ended");
    assert property (@(posedge Clock) disable iff (Reset) !DramCke |-> PinCmd == CmdNop)
        else reportValue("command pins", 32'($sampled(PinBits)), 32'(CmdNop));
    assert property (@(posedge Clock) disable iff (Reset)
        (PinCmd != CmdNop && CmdCount != 3'd4) |-> PinCmd == InitExpect)
        else reportValue("init command", 32'($sampled(PinBits)), 32'($sampled(InitExpect)));
    assert property (@(posedge Clock) disable iff (Reset)
        PinCmd == CmdLoadMode |-> DramAddr == ModeRegValue)
        else reportValue("DramAddr", 32'($sampled(DramAddr)), 32'(ModeRegValue));
    assert property (@(posedge Clock) disable iff (Reset)
        (PinCmd == CmdRead || PinCmd == CmdWrite) |-> SinceActive >= 16'(TRcd))
        else reportRule("column command came too soon after ACTIVE");
    assert property (@(posedge Clock) disable iff (Reset)
        PinCmd == CmdActive |-> SinceRefresh >= 16'(TRfc))
        else reportRule("ACTIVE came too soon after REFRESH");
    // A due refresh can wait behind one running burst
    assert property (@(posedge Clock) disable iff (Reset)
        CmdCount == 3'd4 |-> SinceRefresh <= 16'(RefreshInterval + BurstLength))
        else reportRule("refresh interval was exceeded");
    assert property (@(posedge Clock) disable iff (Reset)
        PinCmd == CmdWrite |-> DramBa == 2'd0)
        else reportValue("DramBa", 32'($sampled(DramBa)), 32'd0);
    assert property (@(posedge Clock) disable iff (Reset)
        PinCmd == CmdWrite |-> DramAddr == {2'b00, 1'b1, 5'd0, WriteCount, 3'd0})
        else reportValue("DramAddr", 32'($sampled(DramAddr)),
                         32'({2'b00, 1'b1, 5'd0, $sampled(WriteCount), 3'd0}));
    assert property (@(posedge Clock) disable iff (Reset)
        WriteBeatNow |-> DramDqOe && DramDqOut == ExpectDq)
        else reportValue("DramDqOut", 32'($sampled(DramDqOut)), 32'($sampled(ExpectDq)));
    assert property (@(posedge Clock) disable iff (Reset) !WriteBeatNow |-> !DramDqOe)
        else reportRule("DramDqOe is high outside a write burst");
    // Both byte lanes are always written
    assert property (@(posedge Clock) disable iff (Reset) !DramDqml && !DramDqmh)
        else reportValue("DramDqm", 32'({$sampled(DramDqmh), $sampled(DramDqml)}), 32'd0);
    assert property (@(posedge Clock) disable iff (Reset) $past(Done) |-> Done)
        else reportRule("Done fell before the next reset");
    assert property (@(posedge Clock) disable iff (Reset)
        $past(Done) |-> MismatchCount == $past(MismatchCount))
        else reportRule("MismatchCount changed after Done");

    //*********************************************************************
    // Run control
    //*********************************************************************
    task automatic applyReset();
        Reset = 1'b1;
        repeat (ResetCycles) @(negedge Clock);
        Reset = 1'b0;
    endtask

    task automatic waitForDone();
        do
            @(negedge Clock);
        while (!Done);
    endtask

    // Keeps the run going past Done until one refresh interval has run out
    task automatic waitForRefresh();
        do
            @(negedge Clock);
        while (!RefreshSeen);
    endtask

    task automatic checkRun(input logic [7:0] expectedMismatches);
        assert (MismatchCount == expectedMismatches)
            else reportValue("MismatchCount", 32'(MismatchCount), 32'(expectedMismatches));
        RunsDone++;
    endtask

    // Bursts 0 to 3 sit in bank 0, row 0, columns 0 to 31
    task automatic checkStoredBursts();
        int          idx;
        logic [15:0] got;
        for (idx = 0; idx < 32; idx++) begin
            got = uModel.Mem[{2'b00, 13'd0, 10'(idx)}];
            assert (got == patternWord(2'(idx / 8), 3'(idx % 8)))
                else reportValue("stored word", 32'(got),
                                 32'(patternWord(2'(idx / 8), 3'(idx % 8))));
        end
    endtask

    always @(posedge Clock) begin
        CycleCount = CycleCount + 1;
        if (CycleCount >= CycleLimit) begin
            ErrorCount++;
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Errors: %0d, runs finished: %0d of 2", ErrorCount, RunsDone);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(62));
        Reset    = 1'b1;
        FaultArm = 1'b0;
        FaultCol = 10'd0;
        applyReset();
        waitForDone();
        waitForRefresh();
        checkRun(8'd0);                          // Clean pass
        checkStoredBursts();
        FaultArm = 1'b1;
        FaultCol = 10'($urandom % 32);
        $display("Second run corrupts the word at column %0d", FaultCol);
        applyReset();
        waitForDone();
        waitForRefresh();
        checkRun(8'd1);                          // Exactly the corrupted word differs
        $display("Errors: %0d, runs finished: %0d of 2", ErrorCount, RunsDone);
        if (ErrorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sdramBursts.f
sdramCtrlPkg.sv
sdramTimer.sv
sdramCtrlFsm.sv
sdramDataPath.sv
sdramBurstTester.sv
sdramBurstsTop.sv
sdramModel.sv
tbSdramBursts.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbSdramBursts -f sdramBursts.f \
    -o simSdramBursts || exit 1
Output=$(./obj_dir/simSdramBursts)
echo "$Output"
echo "$Output" | grep -qx "Simulation completed successfully" && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
